/* bench/game_model.svh */
`ifndef GAME_MODEL_SVH
`define GAME_MODEL_SVH

localparam int FIELD_W     = 551;
localparam int FIELD_H     = 401;
localparam int PLAYER_W    = 47;
localparam int PLAYER_H    = 41;
localparam int BLOCK_W     = 25;
localparam int BLOCK_H     = 42;
localparam int FLAKE_W     = 24;
localparam int FLAKE_H     = 26;
localparam int MONSTER_W   = 34;
localparam int MONSTER_H   = 33;
localparam int START_X     = 10;
localparam int START_Y     = 267;
localparam int HEALTH_INIT = 5;

// model registers hold their values after the latest rising edge
logic [14:0]           m_got;
logic [1:0]            m_frozen;
logic [1:0]            m_prev;
logic                  m_hit;
logic                  m_rst;
logic                  m_up;
logic                  m_left;
logic                  m_down;
logic                  m_right;
int                    m_cnt_x;
int                    m_cnt_y;
int                    m_x;
int                    m_y;
int                    m_score;
int                    m_health;
game_pkg::game_state_e m_state;
logic [31:0]           lfsr;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit taken
function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
        lfsr = lfsr_step(lfsr);
        v = (v << 1) | int'(lfsr[0]);
    end
    return v;
endfunction

// half-open spans that share at least one pixel
function automatic bit overlap(input int a, input int a_len, input int b, input int b_len);
    return (a < b + b_len) && (b < a + a_len);
endfunction

function automatic int block_x(input int i);
    return (i < 22) ? 25 * i : (i < 29) ? 100 + 25 * (i - 22) :
           (i < 36) ? 300 + 25 * (i - 29) : 200 + 25 * (i - 36);
endfunction

function automatic int block_y(input int i);
    return (i < 22) ? 400 : (i < 36) ? 310 : 230;
endfunction

// dir is 0 up, 1 left, 2 down, 3 right
function automatic bit blocked(input int x, input int y, input int dir);
    bit b;
    int bx;
    int by;
    b = (dir == 0) ? (y == 0) : (dir == 1) ? (x == 0) :
        (dir == 2) ? (y + PLAYER_H == FIELD_H) : (x + PLAYER_W == FIELD_W);
    for (int i = 0; i < 50; i++) begin
        bx = block_x(i);
        by = block_y(i);
        case (dir)
            0: b |= overlap(x, PLAYER_W, bx, BLOCK_W) && (y == by + BLOCK_H);
            1: b |= overlap(y, PLAYER_H, by, BLOCK_H) && (x == bx + BLOCK_W);
            2: b |= overlap(x, PLAYER_W, bx, BLOCK_W) && (y + PLAYER_H == by);
            default: b |= overlap(y, PLAYER_H, by, BLOCK_H) && (x + PLAYER_W == bx);
        endcase
    end
    return b;
endfunction

task automatic model_init();
    m_got    = '0;
    m_frozen = '0;
    m_prev   = '0;
    m_hit    = 1'b0;
    m_rst    = 1'b0;
    m_up     = 1'b0;
    m_left   = 1'b0;
    m_down   = 1'b0;
    m_right  = 1'b0;
    m_cnt_x  = 0;
    m_cnt_y  = 0;
    m_x      = START_X;
    m_y      = START_Y;
    m_score  = 0;
    m_health = HEALTH_INIT;
    m_state  = game_pkg::GAME_READY;
    obs_x    = START_X;
    obs_y    = START_Y;
endtask

// advance the model by one rising edge from the position seen before it
task automatic model_edge();
    logic [14:0]           got_n;
    logic [1:0]            frz_n;
    logic [1:0]            prev_n;
    logic                  hit_n;
    logic                  x_ov;
    int                    mx;
    int                    my;
    int                    hp_n;
    game_pkg::game_state_e st_n;

    m_x = m_rst ? START_X : obs_x;
    m_y = m_rst ? START_Y : obs_y;
    if (m_rst) begin
        m_cnt_x = 0;
        m_cnt_y = 0;
    end else if (m_state == game_pkg::GAME_PLAY) begin
        if (m_left || m_right) begin
            if (m_cnt_x == STEP_CYCLES) begin
                m_cnt_x = 0;
                if (m_left && !m_right && !blocked(obs_x, obs_y, 1)) begin
                    m_x = obs_x - 1;
                end else if (m_right && !blocked(obs_x, obs_y, 3)) begin
                    m_x = obs_x + 1;
                end
            end else begin
                m_cnt_x++;
            end
        end
        if (m_up || m_down) begin
            if (m_cnt_y == STEP_CYCLES) begin
                m_cnt_y = 0;
                if (m_up && !m_down && !blocked(obs_x, obs_y, 0)) begin
                    m_y = obs_y - 1;
                end else if (m_down && !blocked(obs_x, obs_y, 2)) begin
                    m_y = obs_y + 1;
                end
            end else begin
                m_cnt_y++;
            end
        end
    end

    // score, health and state from the previous flags
    st_n = m_state;
    hp_n = m_health;
    m_score = 0;
    if (m_rst) begin
        st_n = (m_state == game_pkg::GAME_READY) ? game_pkg::GAME_PLAY : game_pkg::GAME_READY;
        hp_n = HEALTH_INIT;
    end else begin
        for (int i = 0; i < 15; i++) begin
            m_score += int'(m_got[i]);
        end
        if (m_hit && m_state == game_pkg::GAME_PLAY && m_health > 0) begin
            hp_n = m_health - 1;
        end
        if (m_state == game_pkg::GAME_PLAY && &m_got) begin
            st_n = game_pkg::GAME_WIN;
        end else if (m_state == game_pkg::GAME_PLAY && m_health == 0) begin
            st_n = game_pkg::GAME_LOSE;
        end
    end
    m_state  = st_n;
    m_health = hp_n;

    got_n = m_got;
    frz_n = m_frozen;
    hit_n = 1'b0;
    for (int i = 0; i < 15; i++) begin
        if (overlap(obs_x, PLAYER_W, 30, FLAKE_W) &&
            overlap(obs_y, PLAYER_H, 26 * i, FLAKE_H)) begin
            got_n[i] = 1'b1;
        end
    end
    for (int m = 0; m < 2; m++) begin
        mx = (m == 0) ? 250 : 300;
        my = (m == 0) ? 197 : 367;
        x_ov = overlap(obs_x, PLAYER_W, mx, MONSTER_W);
        prev_n[m] = x_ov && overlap(obs_y, PLAYER_H, my, MONSTER_H);
        hit_n |= prev_n[m] && !m_prev[m] && !m_frozen[m];
        if (x_ov && obs_y + PLAYER_H == my) begin
            frz_n[m] = 1'b1;
        end
    end
    m_got    = m_rst ? 15'd0 : got_n;
    m_frozen = m_rst ? 2'd0 : frz_n;
    m_prev   = m_rst ? 2'd0 : prev_n;
    m_hit    = m_rst ? 1'b0 : hit_n;

    // key levels sampled from the inputs of this edge
    m_rst = code_valid_i && !break_i && code_i == game_pkg::KEY_R;
    if (code_valid_i) begin
        m_up    = !break_i && code_i == game_pkg::KEY_W;
        m_left  = !break_i && code_i == game_pkg::KEY_A;
        m_down  = !break_i && code_i == game_pkg::KEY_S;
        m_right = !break_i && code_i == game_pkg::KEY_D;
    end
endtask

`endif

/* bench/tb_platform.sv */
module tb_platform;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int STEP_CYCLES = 4;

    logic                  clk;
    logic                  rst_n_i;
    logic                  code_valid_i;
    logic [7:0]            code_i;
    logic                  break_i;
    game_pkg::xcoord_t     pos_x_o;
    game_pkg::ycoord_t     pos_y_o;
    logic [3:0]            score_o;
    logic [3:0]            health_o;
    game_pkg::game_state_e game_state_o;

    int         errors;
    int         checks;
    int         mark;
    int         tally_errs;
    int         obs_x;
    int         obs_y;
    logic [7:0] keys [4];

    `include "game_model.svh"

    platform_top #(
        .STEP_CYCLES (STEP_CYCLES)
    ) u_platform_top (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .code_valid_i (code_valid_i),
        .code_i       (code_i),
        .break_i      (break_i),
        .pos_x_o      (pos_x_o),
        .pos_y_o      (pos_y_o),
        .score_o      (score_o),
        .health_o     (health_o),
        .game_state_o (game_state_o)
    );

    always #4 clk = ~clk;

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, msg, got, exp);
        end
    endtask

    // one clock and a check of all outputs against the model
    task automatic next_cycle();
        int e0;
        @(negedge clk);
        model_edge();
        compare(pos_x_o, m_x, "pos_x");
        compare(pos_y_o, m_y, "pos_y");
        e0 = errors;
        compare(score_o, m_score, "score");
        compare(health_o, m_health, "health");
        compare(game_state_o, m_state, "game state");
        tally_errs += errors - e0;
        obs_x = int'(pos_x_o);
        obs_y = int'(pos_y_o);
    endtask

    task automatic send_code(input logic [7:0] code, input logic brk);
        code_valid_i = 1'b1;
        code_i       = code;
        break_i      = brk;
        next_cycle();
        code_valid_i = 1'b0;
        break_i      = 1'b0;
    endtask

    task automatic wait_state(input game_pkg::game_state_e s, input int limit);
        int n;
        n = 0;
        while (game_state_o != s && n < limit) begin
            next_cycle();
            n++;
        end
        if (game_state_o != s) begin
            errors++;
            $display("timeout: state did not reach %s within %0d cycles", s.name(), limit);
        end
    endtask

    // hold a key until blocked, until x reaches stop_x, or until play ends
    task automatic walk(input logic [7:0] code, input int dir, input int stop_x);
        int n;
        send_code(code, 1'b0);
        for (n = 0; n < 4000; n++) begin
            if (game_state_o != game_pkg::GAME_PLAY) break;
            if (stop_x < 0 ? blocked(obs_x, obs_y, dir) : obs_x == stop_x) break;
            next_cycle();
        end
        if (n == 4000) begin
            errors++;
            $display("timeout: player walk did not finish within 4000 cycles");
        end
    endtask

    task automatic return_to_ready();
        send_code(game_pkg::KEY_R, 1'b0);
        wait_state(game_pkg::GAME_READY, 4);
        compare(pos_x_o, START_X, "start x after restart");
        compare(pos_y_o, START_Y, "start y after restart");
        compare(score_o, 0, "score after restart");
        compare(health_o, HEALTH_INIT, "health after restart");
    endtask

    task automatic enter_play();
        if (game_state_o != game_pkg::GAME_READY) begin
            return_to_ready();
        end
        send_code(game_pkg::KEY_R, 1'b0);
        wait_state(game_pkg::GAME_PLAY, 4);
    endtask

    task automatic report(input string name, input int errs);
        $display("%s: %s (%0d mismatches)", name, (errs == 0) ? "pass" : "fail", errs);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        code_valid_i = 1'b0;
        code_i       = 8'h00;
        break_i      = 1'b0;
        errors       = 0;
        checks       = 0;
        tally_errs   = 0;
        lfsr         = 32'h69c5;
        keys         = '{game_pkg::KEY_W, game_pkg::KEY_A, game_pkg::KEY_S, game_pkg::KEY_D};
        model_init();
        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;

        mark = errors;
        compare(pos_x_o, START_X, "reset x");
        compare(pos_y_o, START_Y, "reset y");
        compare(score_o, 0, "reset score");
        compare(health_o, HEALTH_INIT, "reset health");
        compare(game_state_o, game_pkg::GAME_READY, "reset state");
        send_code(game_pkg::KEY_R, 1'b0);
        wait_state(game_pkg::GAME_PLAY, 3);
        report("test 1 reset and start", errors - mark);

        // random keys with a restart whenever a game ends
        mark       = errors;
        tally_errs = 0;
        for (int c = 0; c < 3000; c++) begin
            if (game_state_o != game_pkg::GAME_PLAY) begin
                enter_play();
            end else if (take_bits(4) == 0) begin
                send_code(keys[take_bits(2)], take_bits(3) == 0);
            end else begin
                next_cycle();
            end
        end
        report("test 2 random motion", errors - mark - tally_errs);
        report("test 3 score health state", tally_errs);

        mark = errors;
        enter_play();
        walk(game_pkg::KEY_W, 0, -1);
        walk(game_pkg::KEY_S, 2, -1);
        wait_state(game_pkg::GAME_WIN, 4);
        compare(score_o, 15, "score at win");
        report("test 4 collect all flakes", errors - mark);

        // in and out of the floor monster until health runs out
        mark = errors;
        enter_play();
        walk(game_pkg::KEY_S, 2, -1);
        for (int k = 0; k < HEALTH_INIT; k++) begin
            walk(game_pkg::KEY_D, 3, 254);
            walk(game_pkg::KEY_A, 1, 253);
            compare(health_o, HEALTH_INIT - k - 1, "health after monster contact");
        end
        wait_state(game_pkg::GAME_LOSE, 4);
        report("test 5 damage and lose", errors - mark);

        mark = errors;
        return_to_ready();
        report("test 6 restart from lose", errors - mark);

        $display("%0d checks, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* common/game_pkg.sv */
package game_pkg;

    typedef logic [9:0] xcoord_t;
    typedef logic [8:0] ycoord_t;

    typedef enum logic [1:0] {
        GAME_READY = 2'b00,
        GAME_PLAY  = 2'b01,
        GAME_LOSE  = 2'b10,
        GAME_WIN   = 2'b11
    } game_state_e;

    // make codes of scan code set 2
    localparam logic [7:0] KEY_W = 8'h1D;
    localparam logic [7:0] KEY_A = 8'h1C;
    localparam logic [7:0] KEY_S = 8'h1B;
    localparam logic [7:0] KEY_D = 8'h23;
    localparam logic [7:0] KEY_R = 8'h2D;

    localparam xcoord_t FIELD_W   = 10'd551;
    localparam ycoord_t FIELD_H   = 9'd401;
    localparam xcoord_t PLAYER_W  = 10'd47;
    localparam ycoord_t PLAYER_H  = 9'd41;
    localparam xcoord_t BLOCK_W   = 10'd25;
    localparam ycoord_t BLOCK_H   = 9'd42;
    localparam xcoord_t FLAKE_W   = 10'd24;
    localparam ycoord_t FLAKE_H   = 9'd26;
    localparam xcoord_t MONSTER_W = 10'd34;
    localparam ycoord_t MONSTER_H = 9'd33;

    localparam logic [5:0] NUM_BLOCKS   = 6'd50;
    localparam logic [5:0] NUM_FLAKES   = 6'd15;
    localparam logic [5:0] NUM_MONSTERS = 6'd2;

    localparam xcoord_t    START_X     = 10'd10;
    localparam ycoord_t    START_Y     = 9'd267;
    localparam logic [3:0] HEALTH_INIT = 4'd5;

    typedef xcoord_t block_x_t [NUM_BLOCKS];
    typedef ycoord_t block_y_t [NUM_BLOCKS];
    typedef ycoord_t flake_y_t [NUM_FLAKES];

    // floor row, two middle ledges, upper ledge
    function automatic block_x_t block_x_init();
        block_x_t t;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            if (i < 22) begin
                t[i] = xcoord_t'(25 * i);
            end else if (i < 29) begin
                t[i] = xcoord_t'(100 + 25 * (i - 22));
            end else if (i < 36) begin
                t[i] = xcoord_t'(300 + 25 * (i - 29));
            end else begin
                t[i] = xcoord_t'(200 + 25 * (i - 36));
            end
        end
        return t;
    endfunction

    function automatic block_y_t block_y_init();
        block_y_t t;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            t[i] = (i < 22) ? 9'd400 : (i < 36) ? 9'd310 : 9'd230;
        end
        return t;
    endfunction

    function automatic flake_y_t flake_y_init();
        flake_y_t t;
        for (int i = 0; i < NUM_FLAKES; i++) begin
            t[i] = ycoord_t'(26 * i);
        end
        return t;
    endfunction

    localparam block_x_t BLOCK_X = block_x_init();
    localparam block_y_t BLOCK_Y = block_y_init();

    // one column of flakes
    localparam xcoord_t FLAKE_X [NUM_FLAKES] = '{default: 10'd30};
    localparam flake_y_t FLAKE_Y = flake_y_init();

    localparam xcoord_t MONSTER_X [NUM_MONSTERS] = '{10'd250, 10'd300};
    localparam ycoord_t MONSTER_Y [NUM_MONSTERS] = '{9'd197, 9'd367};

    // half-open spans [a, a+a_len) and [b, b+b_len) share a pixel
    function automatic logic spans_overlap(input int a, input int a_len,
                                           input int b, input int b_len);
        return (a < b + b_len) && (b < a + a_len);
    endfunction

endpackage

/* motion/ground_collision.sv */
module ground_collision (
    input  game_pkg::xcoord_t pos_x_i,
    input  game_pkg::ycoord_t pos_y_i,
    output logic              blk_down_o,
    output logic              blk_up_o,
    output logic              blk_right_o,
    output logic              blk_left_o
);

    int px;
    int py;

    assign px = int'(pos_x_i);
    assign py = int'(pos_y_i);

    always_comb begin
        int  bx;
        int  by;
        logic x_ov;
        logic y_ov;

        // field edges first
        blk_left_o  = (px == 0);
        blk_up_o    = (py == 0);
        blk_right_o = (px + int'(game_pkg::PLAYER_W) == int'(game_pkg::FIELD_W));
        blk_down_o  = (py + int'(game_pkg::PLAYER_H) == int'(game_pkg::FIELD_H));

        for (int i = 0; i < game_pkg::NUM_BLOCKS; i++) begin
            bx   = int'(game_pkg::BLOCK_X[i]);
            by   = int'(game_pkg::BLOCK_Y[i]);
            x_ov = game_pkg::spans_overlap(px, int'(game_pkg::PLAYER_W),
                                           bx, int'(game_pkg::BLOCK_W));
            y_ov = game_pkg::spans_overlap(py, int'(game_pkg::PLAYER_H),
                                           by, int'(game_pkg::BLOCK_H));

            // standing on top of a block
            if (x_ov && (py + int'(game_pkg::PLAYER_H) == by)) begin
                blk_down_o = 1'b1;
            end
            // head against the underside
            if (x_ov && (py == by + int'(game_pkg::BLOCK_H))) begin
                blk_up_o = 1'b1;
            end
            if (y_ov && (px + int'(game_pkg::PLAYER_W) == bx)) begin
                blk_right_o = 1'b1;
            end
            if (y_ov && (px == bx + int'(game_pkg::BLOCK_W))) begin
                blk_left_o = 1'b1;
            end
        end
    end

endmodule

/* motion/motion_ctrl.sv */
module motion_ctrl #(
    parameter int STEP_CYCLES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  up_i,
    input  logic                  left_i,
    input  logic                  down_i,
    input  logic                  right_i,
    input  logic                  restart_i,
    input  game_pkg::game_state_e state_i,
    output game_pkg::xcoord_t     pos_x_o,
    output game_pkg::ycoord_t     pos_y_o
);

    localparam int CNT_W = $clog2(STEP_CYCLES + 2);

    logic [CNT_W-1:0] cnt_x;
    logic [CNT_W-1:0] cnt_y;
    logic             blk_down;
    logic             blk_up;
    logic             blk_right;
    logic             blk_left;
    logic             playing;
    logic             go_left;
    logic             go_up;

    ground_collision u_ground_collision (
        .pos_x_i     (pos_x_o),
        .pos_y_i     (pos_y_o),
        .blk_down_o  (blk_down),
        .blk_up_o    (blk_up),
        .blk_right_o (blk_right),
        .blk_left_o  (blk_left)
    );

    assign playing = (state_i == game_pkg::GAME_PLAY);

    // right and down win when both keys of an axis are held
    assign go_left = left_i & ~right_i;
    assign go_up   = up_i & ~down_i;

    // x axis step timer
    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            cnt_x   <= '0;
            pos_x_o <= game_pkg::START_X;
        end else if (playing && (left_i || right_i)) begin
            if (cnt_x == CNT_W'(STEP_CYCLES)) begin
                cnt_x <= '0;
                if (go_left && !blk_left) begin
                    pos_x_o <= pos_x_o - 1'b1;
                end else if (right_i && !blk_right) begin
                    pos_x_o <= pos_x_o + 1'b1;
                end
            end else begin
                cnt_x <= cnt_x + 1'b1;
            end
        end
    end

    // y axis step timer
    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            cnt_y   <= '0;
            pos_y_o <= game_pkg::START_Y;
        end else if (playing && (up_i || down_i)) begin
            if (cnt_y == CNT_W'(STEP_CYCLES)) begin
                cnt_y <= '0;
                if (go_up && !blk_up) begin
                    pos_y_o <= pos_y_o - 1'b1;
                end else if (down_i && !blk_down) begin
                    pos_y_o <= pos_y_o + 1'b1;
                end
            end else begin
                cnt_y <= cnt_y + 1'b1;
            end
        end
    end

endmodule

/* platform_game.f */
+incdir+bench
common/game_pkg.sv
verilog/key_decoder.sv
motion/ground_collision.sv
motion/motion_ctrl.sv
verilog/contact_detect.sv
verilog/game_tally.sv
verilog/platform_top.sv
bench/tb_platform.sv

/* verilog/contact_detect.sv */
module contact_detect (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               restart_i,
    input  game_pkg::xcoord_t                  pos_x_i,
    input  game_pkg::ycoord_t                  pos_y_i,
    output logic [game_pkg::NUM_FLAKES-1:0]    flake_got_o,
    output logic                               hit_o
);

    logic [game_pkg::NUM_FLAKES-1:0]   flake_ov;
    logic [game_pkg::NUM_MONSTERS-1:0] mon_ov;
    logic [game_pkg::NUM_MONSTERS-1:0] stand_on;
    logic [game_pkg::NUM_MONSTERS-1:0] frozen;
    logic [game_pkg::NUM_MONSTERS-1:0] prev_ov;
    int                                px;
    int                                py;

    assign px = int'(pos_x_i);
    assign py = int'(pos_y_i);

    always_comb begin
        for (int i = 0; i < game_pkg::NUM_FLAKES; i++) begin
            flake_ov[i] =
                game_pkg::spans_overlap(px, int'(game_pkg::PLAYER_W),
                                        int'(game_pkg::FLAKE_X[i]), int'(game_pkg::FLAKE_W)) &&
                game_pkg::spans_overlap(py, int'(game_pkg::PLAYER_H),
                                        int'(game_pkg::FLAKE_Y[i]), int'(game_pkg::FLAKE_H));
        end
    end

    always_comb begin
        logic x_ov;

        for (int m = 0; m < game_pkg::NUM_MONSTERS; m++) begin
            x_ov = game_pkg::spans_overlap(px, int'(game_pkg::PLAYER_W),
                                           int'(game_pkg::MONSTER_X[m]),
                                           int'(game_pkg::MONSTER_W));
            mon_ov[m] = x_ov &&
                game_pkg::spans_overlap(py, int'(game_pkg::PLAYER_H),
                                        int'(game_pkg::MONSTER_Y[m]),
                                        int'(game_pkg::MONSTER_H));
            // feet resting on the monster top freeze it
            stand_on[m] = x_ov &&
                (py + int'(game_pkg::PLAYER_H) == int'(game_pkg::MONSTER_Y[m]));
        end
    end

    // sticky flags and edge detect on monster overlap
    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            flake_got_o <= '0;
            frozen      <= '0;
            prev_ov     <= '0;
            hit_o       <= 1'b0;
        end else begin
            flake_got_o <= flake_got_o | flake_ov;
            frozen      <= frozen | stand_on;
            prev_ov     <= mon_ov;
            hit_o       <= |(mon_ov & ~prev_ov & ~frozen);
        end
    end

endmodule

/* verilog/game_tally.sv */
module game_tally (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            restart_i,
    input  logic [game_pkg::NUM_FLAKES-1:0] flake_got_i,
    input  logic                            hit_i,
    output logic [3:0]                      score_o,
    output logic [3:0]                      health_o,
    output game_pkg::game_state_e           state_o
);

    logic [3:0] flake_cnt;

    // population count of collected flakes
    always_comb begin
        flake_cnt = '0;
        for (int i = 0; i < game_pkg::NUM_FLAKES; i++) begin
            flake_cnt = flake_cnt + 4'(flake_got_i[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            score_o  <= '0;
            health_o <= game_pkg::HEALTH_INIT;
            state_o  <= game_pkg::GAME_READY;
        end else if (restart_i) begin
            score_o  <= '0;
            health_o <= game_pkg::HEALTH_INIT;
            case (state_o)
                game_pkg::GAME_READY: state_o <= game_pkg::GAME_PLAY;
                default:              state_o <= game_pkg::GAME_READY;
            endcase
        end else begin
            score_o <= flake_cnt;
            // health saturates at zero
            if (hit_i && state_o == game_pkg::GAME_PLAY && health_o != 4'd0) begin
                health_o <= health_o - 1'b1;
            end
            case (state_o)
                game_pkg::GAME_PLAY: begin
                    if (&flake_got_i) begin
                        state_o <= game_pkg::GAME_WIN;
                    end else if (health_o == 4'd0) begin
                        state_o <= game_pkg::GAME_LOSE;
                    end
                end
                default: state_o <= state_o;
            endcase
        end
    end

endmodule

/* verilog/key_decoder.sv */
module key_decoder (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       code_valid_i,
    input  logic [7:0] code_i,
    input  logic       break_i,
    output logic       up_o,
    output logic       left_o,
    output logic       down_o,
    output logic       right_o,
    output logic       restart_o
);

    logic make;

    // a release of any key counts as no key held
    assign make = code_valid_i & ~break_i;

    // direction levels only change on a strobe
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            up_o    <= 1'b0;
            left_o  <= 1'b0;
            down_o  <= 1'b0;
            right_o <= 1'b0;
        end else if (code_valid_i) begin
            up_o    <= make && (code_i == game_pkg::KEY_W);
            left_o  <= make && (code_i == game_pkg::KEY_A);
            down_o  <= make && (code_i == game_pkg::KEY_S);
            right_o <= make && (code_i == game_pkg::KEY_D);
        end
    end

    // restart is a single cycle pulse per make of R
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            restart_o <= 1'b0;
        end else begin
            restart_o <= make && (code_i == game_pkg::KEY_R);
        end
    end

endmodule

/* verilog/platform_top.sv */
module platform_top #(
    parameter int STEP_CYCLES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  code_valid_i,
    input  logic [7:0]            code_i,
    input  logic                  break_i,
    output game_pkg::xcoord_t     pos_x_o,
    output game_pkg::ycoord_t     pos_y_o,
    output logic [3:0]            score_o,
    output logic [3:0]            health_o,
    output game_pkg::game_state_e game_state_o
);

    logic                            up;
    logic                            left;
    logic                            down;
    logic                            right;
    logic                            restart;
    logic [game_pkg::NUM_FLAKES-1:0] flake_got;
    logic                            hit;

    key_decoder u_key_decoder (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .code_valid_i (code_valid_i),
        .code_i       (code_i),
        .break_i      (break_i),
        .up_o         (up),
        .left_o       (left),
        .down_o       (down),
        .right_o      (right),
        .restart_o    (restart)
    );

    motion_ctrl #(
        .STEP_CYCLES (STEP_CYCLES)
    ) u_motion_ctrl (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .up_i      (up),
        .left_i    (left),
        .down_i    (down),
        .right_i   (right),
        .restart_i (restart),
        .state_i   (game_state_o),
        .pos_x_o   (pos_x_o),
        .pos_y_o   (pos_y_o)
    );

    contact_detect u_contact_detect (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .restart_i   (restart),
        .pos_x_i     (pos_x_o),
        .pos_y_i     (pos_y_o),
        .flake_got_o (flake_got),
        .hit_o       (hit)
    );

    game_tally u_game_tally (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .restart_i   (restart),
        .flake_got_i (flake_got),
        .hit_i       (hit),
        .score_o     (score_o),
        .health_o    (health_o),
        .state_o     (game_state_o)
    );

endmodule
